// File: audio_pkg.sv
/*
 * Shared localparams, register offsets, frame and control word types,
 * the bus word union and the I2S clock level struct
 */
`default_nettype none

package audio_pkg;

    // Sample and FIFO geometry
    localparam int SAMPLE_W   = 16;
    localparam int FIFO_DEPTH = 16;
    localparam int PTR_W      = 4;
    localparam int LEVEL_W    = 5;

    // I2S timing, in clk_i cycles and sclk periods
    localparam int SCLK_DIV       = 4;
    localparam int SCLK_CNT_W     = 2;
    localparam int BITS_PER_FRAME = 32;
    localparam int BIT_CNT_W      = 5;

    // Word offsets, decoded from address bits 3:2
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_STATUS = 2'd1;
    localparam logic [1:0] REG_DATA   = 2'd2;
    localparam logic [1:0] REG_THRESH = 2'd3;

    localparam logic [LEVEL_W-1:0] THRESH_RESET = 5'd4;

    // Left sample sits in the upper half of the bus word
    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
    } sample_frame_t;

    // Clear bits line up with the flag positions in REG_STATUS
    typedef struct packed {
        logic [28:0] reserved;
        logic        underrun_clr;
        logic        overflow_clr;
        logic        enable;
    } ctrl_word_t;

    typedef union packed {
        sample_frame_t frame;
        ctrl_word_t    ctrl;
    } bus_word_u;

    typedef struct packed {
        logic mclk;
        logic sclk;
        logic lrclk;
    } audio_clk_t;

endpackage

`default_nettype wire

// File: reset_logic.sv
/*
 * Reset synchronizer, asynchronous assert and clocked release
 */
`default_nettype none

module reset_logic (
    input  wire  clk_i,
    input  wire  rst_n_i,
    output logic rst_n_o
);

    logic [1:0] sync_q;

    // Two flops against metastability on the release edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    assign rst_n_o = sync_q[1];

endmodule

`default_nettype wire

// File: audio_regs.sv
/*
 * Wishbone register slave: control, status, threshold,
 * FIFO push path and sticky overflow and underrun flags
 */
`default_nettype none

module audio_regs (
    input  wire                           clk_i,
    input  wire                           rst_n_i,
    input  wire  [31:0]                   wb_adr_i,
    input  wire  [31:0]                   wb_dat_i,
    output logic [31:0]                   wb_dat_o,
    input  wire                           wb_we_i,
    input  wire  [3:0]                    wb_sel_i,
    input  wire                           wb_stb_i,
    output logic                          wb_ack_o,
    input  wire                           full_i,
    input  wire  [audio_pkg::LEVEL_W-1:0] level_i,
    input  wire                           low_i,
    input  wire                           underrun_i,
    output logic                          enable_o,
    output logic [audio_pkg::LEVEL_W-1:0] thresh_o,
    output logic                          push_o,
    output audio_pkg::sample_frame_t      push_frame_o
);
    import audio_pkg::*;

    bus_word_u   wr_word;
    logic [1:0]  reg_sel;
    logic        wr_en;
    logic        data_wr;
    logic        status_wr;
    logic        overflow_q;
    logic        underrun_q;
    logic [31:0] rd_data;

    assign wr_word   = wb_dat_i;
    assign reg_sel   = wb_adr_i[3:2];
    assign wr_en     = wb_ack_o & wb_stb_i & wb_we_i;
    assign data_wr   = wr_en & (reg_sel == REG_DATA);
    assign status_wr = wr_en & (reg_sel == REG_STATUS);

    // Single-cycle ack, one cycle after strobe is seen
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_stb_i & ~wb_ack_o;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_o <= 1'b0;
            thresh_o <= THRESH_RESET;
        end else if (wr_en) begin
            if (reg_sel == REG_CTRL) begin
                enable_o <= wr_word.ctrl.enable;
            end
            if (reg_sel == REG_THRESH) begin
                thresh_o <= wb_dat_i[LEVEL_W-1:0];
            end
        end
    end

    // Sticky flags; a new event wins over a clear in the same cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            overflow_q <= 1'b0;
            underrun_q <= 1'b0;
        end else begin
            if (data_wr && full_i) begin
                overflow_q <= 1'b1;
            end else if (status_wr && wr_word.ctrl.overflow_clr) begin
                overflow_q <= 1'b0;
            end
            if (underrun_i) begin
                underrun_q <= 1'b1;
            end else if (status_wr && wr_word.ctrl.underrun_clr) begin
                underrun_q <= 1'b0;
            end
        end
    end

    // Frames written while full are dropped
    assign push_o       = data_wr & ~full_i;
    assign push_frame_o = wr_word.frame;

    always_comb begin
        case (reg_sel)
            REG_CTRL:   rd_data = {31'b0, enable_o};
            // Level in 12:8, low 4, full 3, underrun 2, overflow 1
            REG_STATUS: rd_data = {19'b0, level_i, 3'b0, low_i, full_i,
                                   underrun_q, overflow_q, 1'b0};
            REG_THRESH: rd_data = {{(32-LEVEL_W){1'b0}}, thresh_o};
            default:    rd_data = '0;
        endcase
    end

    assign wb_dat_o = wb_ack_o ? rd_data : '0;

    ack_single_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o);

    // Only full-word accesses are expected from the CPU
    full_word_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_stb_i |-> (wb_sel_i == 4'hF));

endmodule

`default_nettype wire

// File: sample_fifo.sv
/*
 * Stereo frame FIFO with fill level and low-watermark flag
 */
`default_nettype none

module sample_fifo (
    input  wire                           clk_i,
    input  wire                           rst_n_i,
    input  wire                           push_i,
    input  wire  audio_pkg::sample_frame_t push_frame_i,
    input  wire                           pop_i,
    input  wire  [audio_pkg::LEVEL_W-1:0] thresh_i,
    output audio_pkg::sample_frame_t      head_frame_o,
    output logic [audio_pkg::LEVEL_W-1:0] level_o,
    output logic                          full_o,
    output logic                          empty_o,
    output logic                          low_o
);
    import audio_pkg::*;

    sample_frame_t      mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [LEVEL_W-1:0] level_q;

    // Storage only, no reset
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_frame_i;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            level_q <= '0;
        end else begin
            case ({push_i, pop_i})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

    assign head_frame_o = mem_q[rd_ptr_q];
    assign level_o      = level_q;
    assign full_o       = (level_q == LEVEL_W'(FIFO_DEPTH));
    assign empty_o      = (level_q == '0);
    // Interrupt level, held while at or below threshold
    assign low_o        = (level_q <= thresh_i);

    no_push_full_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_o);

    no_pop_empty_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: i2s_clkgen.sv
/*
 * I2S clock generator: mclk, sclk and lrclk plus bit and frame strobes
 */
`default_nettype none

module i2s_clkgen (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire                   enable_i,
    output audio_pkg::audio_clk_t clk_o,
    output logic                  bit_stb_o,
    output logic                  frame_stb_o
);
    import audio_pkg::*;

    logic [SCLK_CNT_W-1:0] phase_q;
    logic [SCLK_CNT_W-1:0] phase_next;
    logic [BIT_CNT_W-1:0]  bit_cnt_q;
    logic                  mclk_q;
    logic                  sclk_q;
    logic                  lrclk_q;

    // Strobe in the cycle before the falling sclk edge
    assign bit_stb_o   = enable_i && (phase_q == SCLK_CNT_W'(SCLK_DIV - 1));
    assign frame_stb_o = bit_stb_o && (bit_cnt_q == '0);
    // Wraps to zero right after the strobe
    assign phase_next  = phase_q + 1'b1;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q   <= '0;
            bit_cnt_q <= '0;
            mclk_q    <= 1'b0;
            sclk_q    <= 1'b0;
            lrclk_q   <= 1'b0;
        end else if (!enable_i) begin
            // Parked low while playback is off
            phase_q   <= '0;
            bit_cnt_q <= '0;
            mclk_q    <= 1'b0;
            sclk_q    <= 1'b0;
            lrclk_q   <= 1'b0;
        end else begin
            mclk_q  <= ~mclk_q;
            phase_q <= phase_next;
            // sclk high for the second half of each period
            sclk_q  <= (phase_next >= SCLK_CNT_W'(SCLK_DIV / 2));
            if (bit_stb_o) begin
                // Slot index of the bit that starts here
                lrclk_q <= (bit_cnt_q >= BIT_CNT_W'(BITS_PER_FRAME / 2));
                if (bit_cnt_q == BIT_CNT_W'(BITS_PER_FRAME - 1)) begin
                    bit_cnt_q <= '0;
                end else begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
            end
        end
    end

    assign clk_o = '{mclk: mclk_q, sclk: sclk_q, lrclk: lrclk_q};

    // Frame start always drops lrclk into the left channel
    frame_left_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        frame_stb_o |-> bit_stb_o ##1 !clk_o.lrclk);

endmodule

`default_nettype wire

// File: i2s_serializer.sv
/*
 * I2S serializer: frame load, one-bit delayed MSB-first shift,
 * FIFO pop and underrun detection
 */
`default_nettype none

module i2s_serializer (
    input  wire                            clk_i,
    input  wire                            rst_n_i,
    input  wire                            bit_stb_i,
    input  wire                            frame_stb_i,
    input  wire                            empty_i,
    input  wire  audio_pkg::sample_frame_t head_frame_i,
    output logic                           pop_o,
    output logic                           underrun_o,
    output logic                           sdata_o
);
    import audio_pkg::*;

    // Top bit carries the previous right LSB through slot 0
    logic [BITS_PER_FRAME:0] shift_q;
    sample_frame_t           load_frame;

    assign pop_o      = frame_stb_i & ~empty_i;
    assign underrun_o = frame_stb_i & empty_i;

    // Silence when nothing is queued
    assign load_frame = empty_i ? '0 : head_frame_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            shift_q <= '0;
        end else if (frame_stb_i) begin
            shift_q <= {shift_q[BITS_PER_FRAME-1], load_frame};
        end else if (bit_stb_i) begin
            shift_q <= {shift_q[BITS_PER_FRAME-1:0], 1'b0};
        end
    end

    // Changes together with the falling sclk edge
    assign sdata_o = shift_q[BITS_PER_FRAME];

endmodule

`default_nettype wire

// File: psoc_audio.sv
/*
 * Audio peripheral top level: reset sync, registers, FIFO,
 * I2S clock generator and serializer
 */
`default_nettype none

module psoc_audio (
    input  wire         clk_i,
    input  wire         rst_n_i,
    input  wire  [31:0] wb_adr_i,
    input  wire  [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    input  wire         wb_we_i,
    input  wire  [3:0]  wb_sel_i,
    input  wire         wb_stb_i,
    output logic        wb_ack_o,
    output logic        fifo_low_o,
    output logic        i2s_mclk_o,
    output logic        i2s_sdata_o,
    output logic        i2s_sclk_o,
    output logic        i2s_lrclk_o
);
    import audio_pkg::*;

    logic               rst_n;
    logic               enable;
    logic [LEVEL_W-1:0] thresh;
    logic               push;
    sample_frame_t      push_frame;
    sample_frame_t      head_frame;
    logic [LEVEL_W-1:0] level;
    logic               full;
    logic               empty;
    logic               pop;
    logic               underrun;
    logic               bit_stb;
    logic               frame_stb;
    audio_clk_t         aclk;

    reset_logic u_reset_logic (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rst_n_o (rst_n)
    );

    audio_regs u_regs (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_we_i      (wb_we_i),
        .wb_sel_i     (wb_sel_i),
        .wb_stb_i     (wb_stb_i),
        .wb_ack_o     (wb_ack_o),
        .full_i       (full),
        .level_i      (level),
        .low_i        (fifo_low_o),
        .underrun_i   (underrun),
        .enable_o     (enable),
        .thresh_o     (thresh),
        .push_o       (push),
        .push_frame_o (push_frame)
    );

    sample_fifo u_fifo (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n),
        .push_i       (push),
        .push_frame_i (push_frame),
        .pop_i        (pop),
        .thresh_i     (thresh),
        .head_frame_o (head_frame),
        .level_o      (level),
        .full_o       (full),
        .empty_o      (empty),
        .low_o        (fifo_low_o)
    );

    i2s_clkgen u_clkgen (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n),
        .enable_i    (enable),
        .clk_o       (aclk),
        .bit_stb_o   (bit_stb),
        .frame_stb_o (frame_stb)
    );

    i2s_serializer u_serializer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n),
        .bit_stb_i    (bit_stb),
        .frame_stb_i  (frame_stb),
        .empty_i      (empty),
        .head_frame_i (head_frame),
        .pop_o        (pop),
        .underrun_o   (underrun),
        .sdata_o      (i2s_sdata_o)
    );

    // I2S clock pins
    assign i2s_mclk_o  = aclk.mclk;
    assign i2s_sclk_o  = aclk.sclk;
    assign i2s_lrclk_o = aclk.lrclk;

endmodule

`default_nettype wire

// File: tb_psoc_audio.sv
/*
 * Directed testbench for the audio peripheral: Wishbone bus tasks,
 * background I2S decoder, LCG stimulus and checks
 */
`default_nettype none

module tb_psoc_audio;
    timeunit 1ns;
    timeprecision 100ps;
    import audio_pkg::*;

    // Byte addresses of the four registers
    localparam logic [31:0] ADDR_CTRL   = 32'h0;
    localparam logic [31:0] ADDR_STATUS = 32'h4;
    localparam logic [31:0] ADDR_DATA   = 32'h8;
    localparam logic [31:0] ADDR_THRESH = 32'hC;

    // 6 played, 2 silent and 17 pushed frames, plus bus polling and margin
    localparam int FRAME_CYCLES   = 128;
    localparam int TEST_FRAMES    = 26;
    localparam int TIMEOUT_CYCLES = TEST_FRAMES * FRAME_CYCLES * 6;
    localparam int DEC_MAX        = 64;

    logic        clk_i;
    logic        rst_n_i;
    logic [31:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_we_i;
    logic [3:0]  wb_sel_i;
    logic        wb_stb_i;
    logic        wb_ack_o;
    logic        fifo_low_o;
    logic        i2s_mclk_o;
    logic        i2s_sdata_o;
    logic        i2s_sclk_o;
    logic        i2s_lrclk_o;

    int            err_count;
    int            check_count;
    int            cycle_count;
    int            thresh_model;
    logic [31:0]   lcg_state;
    logic          low_at_ack;
    sample_frame_t exp_q [$];

    // Decoder state
    sample_frame_t dec_frames [DEC_MAX];
    int            dec_cnt;
    logic          dec_clr;
    logic [15:0]   dec_acc;
    logic [15:0]   dec_left;
    logic          dec_prev_lr;
    logic          dec_have_left;

    psoc_audio u_psoc_audio (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_we_i     (wb_we_i),
        .wb_sel_i    (wb_sel_i),
        .wb_stb_i    (wb_stb_i),
        .wb_ack_o    (wb_ack_o),
        .fifo_low_o  (fifo_low_o),
        .i2s_mclk_o  (i2s_mclk_o),
        .i2s_sdata_o (i2s_sdata_o),
        .i2s_sclk_o  (i2s_sclk_o),
        .i2s_lrclk_o (i2s_lrclk_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // One bit late: the sample taken at an lrclk change is the previous word's LSB
    always @(posedge i2s_sclk_o or posedge dec_clr) begin
        if (dec_clr) begin
            dec_cnt       <= 0;
            dec_acc       <= '0;
            dec_prev_lr   <= 1'b0;
            dec_have_left <= 1'b0;
        end else begin
            dec_acc     <= {dec_acc[14:0], i2s_sdata_o};
            dec_prev_lr <= i2s_lrclk_o;
            if (i2s_lrclk_o && !dec_prev_lr) begin
                dec_left      <= {dec_acc[14:0], i2s_sdata_o};
                dec_have_left <= 1'b1;
            end else if (!i2s_lrclk_o && dec_prev_lr && dec_have_left) begin
                if (dec_cnt < DEC_MAX) begin
                    dec_frames[dec_cnt] <= {dec_left, dec_acc[14:0], i2s_sdata_o};
                    dec_cnt             <= dec_cnt + 1;
                end
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Holds stb until the ack cycle has ended
    task automatic bus_access(input logic [31:0] addr, input logic we,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk_i);
        #1;
        wb_adr_i = addr;
        wb_we_i  = we;
        wb_dat_i = wdata;
        wb_stb_i = 1'b1;
        do begin
            @(posedge clk_i);
            #1;
        end while (!wb_ack_o);
        rdata      = wb_dat_o;
        low_at_ack = fifo_low_o;
        @(posedge clk_i);
        #1;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] unused_rdata;
        bus_access(addr, 1'b1, wdata, unused_rdata);
    endtask

    task automatic wb_read(input logic [31:0] addr, output logic [31:0] rdata);
        bus_access(addr, 1'b0, 32'h0, rdata);
    endtask

    // Low and full follow from the level and the current threshold
    task automatic expect_status(input string what, input int level,
                                 input logic ovf, input logic unf);
        logic [31:0] rdata;
        logic        low;
        logic        full;
        low  = (level <= thresh_model);
        full = (level == 16);
        wb_read(ADDR_STATUS, rdata);
        check_eq(what, rdata, {19'b0, level[4:0], 3'b0, low, full, unf, ovf, 1'b0});
        check_eq({what, ", fifo_low_o"}, {31'b0, low_at_ack}, {31'b0, low});
    endtask

    // mclk is clk_i divided by 2 while playback runs
    task automatic mclk_rate_check(input int n);
        logic prev;
        @(posedge clk_i);
        #1;
        prev = i2s_mclk_o;
        for (int i = 0; i < n; i++) begin
            @(posedge clk_i);
            #1;
            check_eq("mclk toggle", {31'b0, i2s_mclk_o}, {31'b0, ~prev});
            prev = i2s_mclk_o;
        end
    endtask

    task automatic clear_decoder();
        dec_clr = 1'b1;
        #1;
        dec_clr = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        while (dec_cnt < n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic push_lcg_frames(input int n, input int keep);
        for (int i = 0; i < n; i++) begin
            lcg_state = lcg_next(lcg_state);
            if (i < keep) begin
                exp_q.push_back(lcg_state);
            end
            wb_write(ADDR_DATA, lcg_state);
        end
    endtask

    task automatic reset_state_test();
        logic [31:0] rdata;
        check_eq("ack, sclk, lrclk, sdata, mclk after reset",
                 {27'b0, wb_ack_o, i2s_sclk_o, i2s_lrclk_o, i2s_sdata_o, i2s_mclk_o}, 32'd0);
        check_eq("fifo_low_o after reset", {31'b0, fifo_low_o}, 32'd1);
        expect_status("status after reset", 0, 1'b0, 1'b0);
        wb_read(ADDR_THRESH, rdata);
        check_eq("threshold after reset", rdata, 32'd4);
    endtask

    task automatic register_readback_test();
        logic [31:0] rdata;
        wb_write(ADDR_THRESH, 32'd9);
        thresh_model = 9;
        wb_write(ADDR_CTRL, 32'd0);
        wb_read(ADDR_THRESH, rdata);
        check_eq("threshold readback", rdata, 32'd9);
        wb_read(ADDR_CTRL, rdata);
        check_eq("control readback", rdata, 32'd0);
    endtask

    task automatic playback_test();
        logic [31:0] rdata;
        int          level;
        int          prev_level;
        // Threshold of 3 makes fifo_low_o change during the pushes
        wb_write(ADDR_THRESH, 32'd3);
        thresh_model = 3;
        clear_decoder();
        exp_q.delete();
        for (int i = 0; i < 6; i++) begin
            push_lcg_frames(1, 1);
            expect_status("status after push", i + 1, 1'b0, 1'b0);
        end
        wb_write(ADDR_CTRL, 32'd1);
        mclk_rate_check(8);
        prev_level = 6;
        do begin
            wb_read(ADDR_STATUS, rdata);
            level = int'(rdata[12:8]);
            check_eq("low bit while draining", {31'b0, rdata[4]},
                     {31'b0, level <= thresh_model});
            check_eq("fifo_low_o while draining", {31'b0, low_at_ack},
                     {31'b0, level <= thresh_model});
            if (level > prev_level) begin
                err_count++;
                $display("ERR %0t: level rose from %0d to %0d during playback",
                         $time, prev_level, level);
            end
            prev_level = level;
        end while (level != 0);
        wait_frames(6);
        for (int i = 0; i < 6; i++) begin
            check_eq("played frame", dec_frames[i], exp_q[i]);
        end
    endtask

    task automatic underrun_test();
        wait_frames(8);
        check_eq("first frame after drain", dec_frames[6], 32'd0);
        check_eq("second frame after drain", dec_frames[7], 32'd0);
        wb_write(ADDR_CTRL, 32'd0);
        expect_status("status after underrun", 0, 1'b0, 1'b1);
        wb_write(ADDR_STATUS, 32'h4);
        expect_status("status after underrun clear", 0, 1'b0, 1'b0);
    endtask

    task automatic overflow_test();
        clear_decoder();
        exp_q.delete();
        // The 17th write finds the FIFO full and is dropped
        push_lcg_frames(17, 16);
        expect_status("status after overflow", 16, 1'b1, 1'b0);
        wb_write(ADDR_STATUS, 32'h2);
        expect_status("status after overflow clear", 16, 1'b0, 1'b0);
        wb_write(ADDR_CTRL, 32'd1);
        wait_frames(16);
        for (int i = 0; i < 16; i++) begin
            check_eq("frame played after overflow", dec_frames[i], exp_q[i]);
        end
        wb_write(ADDR_CTRL, 32'd0);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_n_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_we_i      = 1'b0;
        wb_sel_i     = 4'hF;
        wb_stb_i     = 1'b0;
        dec_clr      = 1'b0;
        err_count    = 0;
        check_count  = 0;
        thresh_model = 4;
        lcg_state    = 32'd29;
        low_at_ack   = 1'b0;
        clear_decoder();
        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        // Synchronizer needs two edges before the block leaves reset
        repeat (3) @(posedge clk_i);
        #1;
        reset_state_test();
        register_readback_test();
        playback_test();
        underrun_test();
        overflow_test();
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
audio_pkg.sv
reset_logic.sv
audio_regs.sv
sample_fifo.sv
i2s_clkgen.sv
i2s_serializer.sv
psoc_audio.sv
tb_psoc_audio.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_psoc_audio
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)
